//--- AcqSequencer.sv
module AcqSequencer
	import DaqPkg::*;
#(
	parameter int DrainCycles = 1600
) (
	input  logic   Clk,
	input  logic   reset_n,
	input  logic   ModuleStart,     // Run enable from software
	input  logic   TrigEdge,
	input  logic   ChipFull,
	input  logic   ReadReady,
	input  logic   EndRead,
	input  logic   TailSent,
	input  logic   TransmitDone,
	input  DelayT  AcquisitionTime,
	input  DelayT  EndHoldTime,
	output logic   ResetB,          // Chip digital reset, active low
	output logic   StartAcq,
	output logic   ForceExternalRaz,
	output logic   StartReadout,
	output logic   OnceEnd,
	output logic   AllDone,
	output logic   PwrOnA,          // Analog power pulsing
	output logic   PwrOnD,          // Digital power pulsing
	output logic   PwrOnDac,        // DAC power pulsing
	output logic   IdReq,
	output logic   TailReq,
	output TrigIdT TrigId
);
	SeqStateT State;
	DelayT    DelayCnt;
	TrigIdT   TrigCnt;

	////////////////////
	// Sequencer
	////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			State    <= Idle;
			DelayCnt <= '0;
			TrigCnt  <= '0;
			IdReq    <= 1'b0;
			TailReq  <= 1'b0;
		end
		else begin
			IdReq   <= 1'b0;
			TailReq <= 1'b0;

			// Triggers inside the window still count
			if (State == Acquire && TrigEdge)
				TrigCnt <= TrigCnt + 1'b1;

			case (State)
				Idle: begin
					if (ModuleStart) begin
						State    <= ChipReset;
						DelayCnt <= '0;
						TrigCnt  <= '0; // New run
					end
				end
				ChipReset: State <= PowerOn;
				PowerOn: begin
					if (DelayCnt == TimePowerReset - 1'b1) begin
						State    <= Release;
						DelayCnt <= '0;
					end
					else
						DelayCnt <= DelayCnt + 1'b1;
				end
				Release: begin
					if (DelayCnt == TimeResetStart - 1'b1) begin
						State    <= WaitStart;
						DelayCnt <= '0;
					end
					else
						DelayCnt <= DelayCnt + 1'b1;
				end
				WaitStart: begin
					if (!ModuleStart) begin
						State    <= Drain;
						DelayCnt <= '0;
					end
					else if (TrigEdge) begin
						State   <= Acquire;
						TrigCnt <= TrigCnt + 1'b1;
					end
				end
				Acquire: begin
					// Window closes on time or when the chip memory is full
					if (ChipFull || (DelayCnt + 1'b1 >= AcquisitionTime)) begin
						State    <= WaitRead;
						DelayCnt <= '0;
					end
					else
						DelayCnt <= DelayCnt + 1'b1;
				end
				WaitRead: begin
					if (ReadReady)
						State <= StartRo;
				end
				StartRo: begin
					if (DelayCnt == TimeSro) begin
						State    <= WaitReadDone;
						DelayCnt <= '0;
					end
					else
						DelayCnt <= DelayCnt + 1'b1;
				end
				WaitReadDone: begin
					if (EndRead)
						State <= OnceEndHold;
				end
				OnceEndHold: begin
					if (DelayCnt >= EndHoldTime) begin
						State    <= WaitStart;
						DelayCnt <= '0;
						IdReq    <= 1'b1; // Framer decides if a record is needed
					end
					else
						DelayCnt <= DelayCnt + 1'b1;
				end
				Drain: begin
					// Let the last chip words reach the framer
					if (DelayCnt == DelayT'(DrainCycles - 1)) begin
						State    <= SendTail;
						DelayCnt <= '0;
						TailReq  <= 1'b1;
					end
					else
						DelayCnt <= DelayCnt + 1'b1;
				end
				SendTail: begin
					if (TailSent)
						State <= Done;
				end
				Done: begin
					if (TransmitDone)
						State <= Idle;
				end
				default: State <= Idle;
			endcase
		end
	end

	assign TrigId = TrigCnt;

	////////////////////
	// Chip control
	////////////////////
	assign ResetB           = !(State == ChipReset || State == PowerOn);
	assign StartAcq         = (State == Acquire);
	assign ForceExternalRaz = !StartAcq;
	assign StartReadout     = (State == StartRo);
	assign OnceEnd          = (State == OnceEndHold);
	assign AllDone          = (State == Done);

	// Power stays on for the whole run, digital part after reset
	assign PwrOnD = State inside {PowerOn, Release, WaitStart, Acquire, WaitRead,
		StartRo, WaitReadDone, OnceEndHold};
	assign PwrOnA   = PwrOnD || (State == ChipReset);
	assign PwrOnDac = PwrOnA;

endmodule

//--- DaqPkg.sv
package DaqPkg;

	////////////////////
	// Vector types
	////////////////////
	typedef logic [15:0] DataWordT; // Stream word, ASIC side and USB side
	typedef logic [23:0] TrigIdT;   // Running trigger count
	typedef logic [15:0] DelayT;    // Programmable delays in Clk cycles

	// Acquisition sequencer states
	typedef enum logic [3:0] {
		Idle,
		ChipReset,
		PowerOn,
		Release,
		WaitStart,
		Acquire,
		WaitRead,
		StartRo,
		WaitReadDone,
		OnceEndHold,
		Drain,
		SendTail,
		Done
	} SeqStateT;

	////////////////////
	// Record markers
	////////////////////
	parameter logic [7:0] TrigHeader  = 8'hAA; // Upper trigger-ID word
	parameter logic [7:0] CountHeader = 8'hCC; // Upper count word of the tail
	parameter DataWordT   TailWordA   = 16'hFF45;
	parameter DataWordT   TailWordB   = 16'h45FF;

	// Chip timing in Clk cycles
	parameter DelayT TimePowerReset = 16'd8;  // LVDS receivers wake-up
	parameter DelayT TimeResetStart = 16'd40; // Internal management after reset release
	parameter DelayT TimeSro        = 16'd16;

endpackage

//--- EventFramer.sv
module EventFramer
	import DaqPkg::*;
#(
	parameter int CreditDepth = 8,
	parameter int FifoDepth   = 16
) (
	input  logic     Clk,
	input  logic     reset_n,
	input  DataWordT AsicData,
	input  logic     AsicDataValid,
	input  logic     IdReq,
	input  logic     TailReq,
	input  TrigIdT   TrigId,
	input  logic     CreditReturn,
	output DataWordT DaqData,
	output logic     DaqDataValid,
	output logic     TailSent,
	output logic     DataLost       // Sticky, a chip word was dropped
);
	localparam int AddrW   = $clog2(FifoDepth);
	localparam int CreditW = $clog2(CreditDepth + 1);
	localparam logic [1:0] KindData = 2'd0, KindId = 2'd1, KindTail = 2'd2;

	typedef logic [25:0] EntryT; // Kind on top, then trigger ID or data word

	EntryT              Mem [FifoDepth];
	logic [AddrW:0]     WrPtr, RdPtr;
	logic               Full, Empty, Push, PushId, PushTail, Pop;
	EntryT              PushEntry, Head;
	logic [1:0]         HeadKind, WordIdx, LastIdx;
	TrigIdT             HeadId, PendIdVal, PendTailVal;
	logic               PendId, PendTail, Hit;
	logic [CreditW-1:0] Credit;

	assign Empty = (WrPtr == RdPtr);
	assign Full  = (WrPtr[AddrW] != RdPtr[AddrW]) && (WrPtr[AddrW-1:0] == RdPtr[AddrW-1:0]);

	////////////////////
	// Write side
	////////////////////
	// Chip words cannot wait, records take the next free cycle
	always_comb begin
		PushId   = !AsicDataValid && PendId && !Full;
		PushTail = !AsicDataValid && !PendId && PendTail && !Full;
		Push     = (AsicDataValid && !Full) || PushId || PushTail;
		if (PushId)
			PushEntry = {KindId, PendIdVal};
		else if (PushTail)
			PushEntry = {KindTail, PendTailVal};
		else
			PushEntry = {KindData, 8'h00, AsicData};
	end

	always_ff @(posedge Clk) begin
		if (Push)
			Mem[WrPtr[AddrW-1:0]] <= PushEntry;
		if (IdReq)
			PendIdVal <= TrigId;
		if (TailReq)
			PendTailVal <= TrigId;
	end

	////////////////////
	// Read side
	////////////////////
	assign Head     = Mem[RdPtr[AddrW-1:0]];
	assign HeadKind = Head[25:24];
	assign HeadId   = Head[23:0];
	assign LastIdx  = (HeadKind == KindTail) ? 2'd3 : (HeadKind == KindId) ? 2'd1 : 2'd0;

	assign DaqDataValid = !Empty && (Credit != '0);
	assign Pop          = DaqDataValid && (WordIdx == LastIdx);

	always_comb begin
		case (HeadKind)
			KindId:   DaqData = (WordIdx == 2'd0) ? {TrigHeader, HeadId[23:16]} : HeadId[15:0];
			KindTail: begin
				case (WordIdx)
					2'd0:    DaqData = TailWordA;
					2'd1:    DaqData = {CountHeader, HeadId[23:16]};
					2'd2:    DaqData = HeadId[15:0];
					default: DaqData = TailWordB;
				endcase
			end
			default:  DaqData = HeadId[15:0];
		endcase
	end

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			WrPtr    <= '0;
			RdPtr    <= '0;
			WordIdx  <= '0;
			Credit   <= CreditW'(CreditDepth); // Sink buffer starts empty
			PendId   <= 1'b0;
			PendTail <= 1'b0;
			Hit      <= 1'b0;
			TailSent <= 1'b0;
			DataLost <= 1'b0;
		end
		else begin
			if (Push)
				WrPtr <= WrPtr + 1'b1;
			if (Pop)
				RdPtr <= RdPtr + 1'b1;
			if (Pop)
				WordIdx <= '0;
			else if (DaqDataValid)
				WordIdx <= WordIdx + 1'b1;
			Credit <= Credit - CreditW'(DaqDataValid) + CreditW'(CreditReturn);

			// ID record only for acquisitions that produced data
			if (IdReq)
				Hit <= 1'b0;
			else if (AsicDataValid)
				Hit <= 1'b1;
			if (IdReq && (Hit || AsicDataValid))
				PendId <= 1'b1;
			else if (PushId)
				PendId <= 1'b0;
			if (TailReq)
				PendTail <= 1'b1;
			else if (PushTail)
				PendTail <= 1'b0;

			TailSent <= Pop && (HeadKind == KindTail);
			if (AsicDataValid && Full)
				DataLost <= 1'b1;
		end
	end

endmodule

//--- InputSync.sv
module InputSync (
	input  logic Clk,
	input  logic reset_n,
	input  logic AcqStart,   // External trigger
	input  logic ChipSatB,   // Chip full, active low
	input  logic EndReadout, // End of chip readout, active high
	output logic TrigEdge,
	output logic ChipFull,
	output logic ReadReady,
	output logic EndRead
);
	// Bit 0 trigger, bit 1 chip full flag, bit 2 end of readout
	localparam logic [2:0] IdleLevel = 3'b010; // ChipSatB rests high

	logic [2:0] Meta;   // First synchronizer stage
	logic [2:0] Stable; // Second synchronizer stage

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			Meta      <= IdleLevel;
			Stable    <= IdleLevel;
			TrigEdge  <= 1'b0;
			ChipFull  <= 1'b0;
			ReadReady <= 1'b0;
		end
		else begin
			Meta   <= {EndReadout, ChipSatB, AcqStart};
			Stable <= Meta;

			TrigEdge  <= Meta[0] & ~Stable[0];  // Rising edge
			ChipFull  <= ~Meta[1] & Stable[1];  // Falling edge, chip memory full
			ReadReady <= Meta[1] & ~Stable[1];  // Rising edge, readout may start
		end
	end

	// Level is enough here, the sequencer only looks at it while waiting
	assign EndRead = Stable[2];

endmodule

//--- SlaveDaq.sv
module SlaveDaq
	import DaqPkg::*;
#(
	parameter int DrainCycles = 1600,
	parameter int CreditDepth = 8,
	parameter int FifoDepth   = 16
) (
	input  logic     Clk,
	input  logic     reset_n,
	input  logic     ModuleStart,
	input  logic     AcqStart,
	input  logic     ChipSatB,
	input  logic     EndReadout,
	input  DelayT    AcquisitionTime,
	input  DelayT    EndHoldTime,
	input  logic     TransmitDone,
	input  DataWordT AsicData,
	input  logic     AsicDataValid,
	input  logic     CreditReturn,
	output logic     ResetB,
	output logic     StartAcq,
	output logic     ForceExternalRaz,
	output logic     StartReadout,
	output logic     OnceEnd,
	output logic     AllDone,
	output logic     PwrOnA,
	output logic     PwrOnD,
	output logic     PwrOnDac,
	output DataWordT DaqData,
	output logic     DaqDataValid,
	output logic     DataLost
);
	logic   TrigEdge, ChipFull, ReadReady, EndRead;
	logic   IdReq, TailReq, TailSent;
	TrigIdT TrigId;

	InputSync uSync (
		.Clk(Clk), .reset_n(reset_n), .AcqStart(AcqStart), .ChipSatB(ChipSatB),
		.EndReadout(EndReadout), .TrigEdge(TrigEdge), .ChipFull(ChipFull),
		.ReadReady(ReadReady), .EndRead(EndRead)
	);

	AcqSequencer #(.DrainCycles(DrainCycles)) uSeq (
		.Clk(Clk), .reset_n(reset_n), .ModuleStart(ModuleStart), .TrigEdge(TrigEdge),
		.ChipFull(ChipFull), .ReadReady(ReadReady), .EndRead(EndRead),
		.TailSent(TailSent), .TransmitDone(TransmitDone),
		.AcquisitionTime(AcquisitionTime), .EndHoldTime(EndHoldTime),
		.ResetB(ResetB), .StartAcq(StartAcq), .ForceExternalRaz(ForceExternalRaz),
		.StartReadout(StartReadout), .OnceEnd(OnceEnd), .AllDone(AllDone),
		.PwrOnA(PwrOnA), .PwrOnD(PwrOnD), .PwrOnDac(PwrOnDac),
		.IdReq(IdReq), .TailReq(TailReq), .TrigId(TrigId)
	);

	EventFramer #(.CreditDepth(CreditDepth), .FifoDepth(FifoDepth)) uFramer (
		.Clk(Clk), .reset_n(reset_n), .AsicData(AsicData), .AsicDataValid(AsicDataValid),
		.IdReq(IdReq), .TailReq(TailReq), .TrigId(TrigId), .CreditReturn(CreditReturn),
		.DaqData(DaqData), .DaqDataValid(DaqDataValid), .TailSent(TailSent),
		.DataLost(DataLost)
	);

endmodule

//--- SlaveDaqTb.sv
module SlaveDaqTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DrainCycles    = 20;
	localparam int CreditDepth    = 4;
	localparam int SroCycles      = 17; // Readout strobe, 16 cycles plus one
	localparam int ReleaseCycles  = 40;
	localparam int NumRows        = 6;
	localparam int WatchdogCycles = 300 + NumRows * 200 + 2 * DrainCycles;

	typedef struct packed {
		logic [15:0] AcqTime;
		logic        Sat;      // Chip fills up inside the window
		logic [7:0]  SatAfter; // Window cycles before the chip is full
		logic [7:0]  Words;
		logic [15:0] HoldTime;
		logic [7:0]  Rate;     // Cycles per returned credit
	} ScenarioT;

	// AcqTime, saturates, after, words, hold, credit rate
	localparam ScenarioT Scenarios [NumRows] = '{
		'{16'd12, 1'b0, 8'd0, 8'd5,  16'd3, 8'd1},
		'{16'd20, 1'b1, 8'd4, 8'd8,  16'd0, 8'd2},
		'{16'd6,  1'b0, 8'd0, 8'd0,  16'd2, 8'd1},
		'{16'd30, 1'b1, 8'd2, 8'd12, 16'd5, 8'd4},
		'{16'd1,  1'b0, 8'd0, 8'd3,  16'd1, 8'd3},
		'{16'd15, 1'b0, 8'd0, 8'd10, 16'd4, 8'd5}
	};

	logic        Clk, reset_n, ModuleStart, AcqStart, ChipSatB, EndReadout, TransmitDone;
	logic [15:0] AcquisitionTime, EndHoldTime, AsicData, DaqData;
	logic        AsicDataValid, CreditReturn, DaqDataValid, DataLost;
	logic        ResetB, StartAcq, ForceExternalRaz, StartReadout, OnceEnd, AllDone;
	logic        PwrOnA, PwrOnD, PwrOnDac;

	logic        CurSat, RunActive;
	int          CurSatAfter, CurWords, CurRate, ErrorCount, WordCount;
	logic [15:0] ExpQ [$];        // Words the sink should see, in order
	logic [31:0] LfsrState = 32'd79806;

	SlaveDaq #(.DrainCycles(DrainCycles), .CreditDepth(CreditDepth), .FifoDepth(16)) uut (
		.Clk(Clk), .reset_n(reset_n), .ModuleStart(ModuleStart), .AcqStart(AcqStart),
		.ChipSatB(ChipSatB), .EndReadout(EndReadout), .AcquisitionTime(AcquisitionTime),
		.EndHoldTime(EndHoldTime), .TransmitDone(TransmitDone), .AsicData(AsicData),
		.AsicDataValid(AsicDataValid), .CreditReturn(CreditReturn), .ResetB(ResetB),
		.StartAcq(StartAcq), .ForceExternalRaz(ForceExternalRaz), .StartReadout(StartReadout),
		.OnceEnd(OnceEnd), .AllDone(AllDone), .PwrOnA(PwrOnA), .PwrOnD(PwrOnD),
		.PwrOnDac(PwrOnDac), .DaqData(DaqData), .DaqDataValid(DaqDataValid), .DataLost(DataLost)
	);

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	task automatic reportError(input string Msg);
		ErrorCount++;
		$display("FAIL @ %0t ns: %s", $time, Msg);
	endtask

	task automatic checkLevel(input string Name, input logic Got, input logic Want);
		if (Got !== Want)
			reportError($sformatf("%s is %b, expected %b", Name, Got, Want));
	endtask

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic stepLfsr();
		logic Out;
		Out = LfsrState[0];
		LfsrState = LfsrState >> 1;
		if (Out)
			LfsrState = LfsrState ^ 32'h80200003;
		return Out;
	endfunction

	function automatic logic [15:0] nextWord();
		logic [15:0] W;
		W = '0;
		for (int B = 0; B < 16; B++)
			W = {W[14:0], stepLfsr()};
		return W;
	endfunction

	////////////////////
	// Chip stand-in
	////////////////////
	initial begin : chipFlag
		int K;
		ChipSatB = 1'b1;
		forever begin
			@(negedge Clk);
			if (StartAcq) begin
				K = 0;
				while (StartAcq) begin
					K++;
					if (CurSat && K == CurSatAfter)
						ChipSatB = 1'b0; // Memory full
					@(negedge Clk);
				end
				ChipSatB = 1'b0; // Busy converting
				repeat (3) @(negedge Clk);
				ChipSatB = 1'b1;
			end
		end
	end

	initial begin : chipReadout
		AsicData      = '0;
		AsicDataValid = 1'b0;
		EndReadout    = 1'b0;
		forever begin
			@(negedge Clk);
			if (StartReadout) begin
				for (int I = 0; I < CurWords; I++) begin
					AsicData      = nextWord();
					AsicDataValid = 1'b1;
					ExpQ.push_back(AsicData);
					@(negedge Clk);
				end
				AsicDataValid = 1'b0;
				while (StartReadout) @(negedge Clk);
				EndReadout = 1'b1;
				repeat (3) @(negedge Clk);
				EndReadout = 1'b0;
			end
		end
	end

	// Sink with a CreditDepth word buffer, drained at the row's rate
	initial begin : sink
		int Outstanding;
		int Gap;
		logic [15:0] Exp;
		Outstanding  = 0;
		Gap          = 0;
		CreditReturn = 1'b0;
		forever begin
			@(negedge Clk);
			CreditReturn = 1'b0;
			if (reset_n && DaqDataValid) begin
				Outstanding++;
				WordCount++;
				if (ExpQ.size() == 0) begin
					ErrorCount++;
					$display("Unexpected extra word %h on the stream at %0t ns", DaqData, $time);
				end
				else begin
					Exp = ExpQ.pop_front();
					if (DaqData !== Exp)
						reportError($sformatf("stream word %h, expected %h", DaqData, Exp));
				end
			end
			if (Outstanding > CreditDepth)
				reportError($sformatf("%0d words outstanding", Outstanding));
			Gap++;
			if (Outstanding > 0 && Gap >= CurRate) begin
				CreditReturn = 1'b1;
				Outstanding--;
				Gap = 0;
			end
		end
	end

	always @(negedge Clk) begin
		if (RunActive && !(PwrOnA && PwrOnD && PwrOnDac))
			reportError("power output low during the run");
	end

	////////////////////
	// Scenario flow
	////////////////////
	task automatic runScenario(input ScenarioT Row, input int TrigNum);
		int N;
		logic [23:0] Id;
		Id              = 24'(TrigNum);
		AcquisitionTime = Row.AcqTime;
		EndHoldTime     = Row.HoldTime;
		CurSat          = Row.Sat;
		CurSatAfter     = int'(Row.SatAfter);
		CurWords        = int'(Row.Words);
		CurRate         = int'(Row.Rate);
		AcqStart = 1'b1;
		repeat (2) @(negedge Clk);
		AcqStart = 1'b0;

		while (!StartAcq) @(negedge Clk);
		N = 0;
		while (StartAcq) begin
			N++;
			if (ForceExternalRaz)
				reportError("ForceExternalRaz high inside the window");
			@(negedge Clk);
		end
		checkLevel("ForceExternalRaz", ForceExternalRaz, 1'b1);
		if (!Row.Sat && N != int'(Row.AcqTime))
			reportError($sformatf("StartAcq lasted %0d cycles, expected %0d", N, Row.AcqTime));
		if (Row.Sat && N >= int'(Row.AcqTime))
			reportError($sformatf("StartAcq lasted %0d cycles despite chip full", N));

		while (!StartReadout) @(negedge Clk);
		N = 0;
		while (StartReadout) begin
			N++;
			@(negedge Clk);
		end
		if (N != SroCycles)
			reportError($sformatf("StartReadout lasted %0d cycles, expected %0d", N, SroCycles));

		while (!OnceEnd) @(negedge Clk);
		N = 0;
		while (OnceEnd) begin
			N++;
			@(negedge Clk);
		end
		if (N != int'(Row.HoldTime) + 1)
			reportError($sformatf("OnceEnd lasted %0d cycles, expected %0d", N, Row.HoldTime + 1));

		if (Row.Words != 0) begin // Empty acquisitions carry no ID record
			ExpQ.push_back({8'hAA, Id[23:16]});
			ExpQ.push_back(Id[15:0]);
		end
	endtask

	initial begin : mainFlow
		logic [23:0] Total;
		reset_n         = 1'b0;
		ModuleStart     = 1'b0;
		AcqStart        = 1'b0;
		TransmitDone    = 1'b0;
		AcquisitionTime = 16'd1;
		EndHoldTime     = 16'd0;
		CurSat          = 1'b0;
		CurRate         = 1;
		RunActive       = 1'b0;
		ErrorCount      = 0;
		WordCount       = 0;
		repeat (8) @(negedge Clk);
		reset_n = 1'b1;
		@(negedge Clk);

		checkLevel("StartAcq", StartAcq, 1'b0);
		checkLevel("StartReadout", StartReadout, 1'b0);
		checkLevel("OnceEnd", OnceEnd, 1'b0);
		checkLevel("AllDone", AllDone, 1'b0);
		checkLevel("DaqDataValid", DaqDataValid, 1'b0);
		checkLevel("PwrOnA", PwrOnA, 1'b0);
		checkLevel("PwrOnD", PwrOnD, 1'b0);
		checkLevel("PwrOnDac", PwrOnDac, 1'b0);
		checkLevel("DataLost", DataLost, 1'b0);
		checkLevel("ResetB", ResetB, 1'b1);
		checkLevel("ForceExternalRaz", ForceExternalRaz, 1'b1);

		// Start-up sequence, chip reset pulse then release wait
		ModuleStart = 1'b1;
		while (ResetB) @(negedge Clk);
		while (!ResetB) @(negedge Clk);
		RunActive = 1'b1;
		repeat (ReleaseCycles + 4) @(negedge Clk);

		for (int R = 0; R < NumRows; R++)
			runScenario(Scenarios[R], R + 1);

		Total       = 24'(NumRows);
		ModuleStart = 1'b0;
		RunActive   = 1'b0;
		ExpQ.push_back(16'hFF45);
		ExpQ.push_back({8'hCC, Total[23:16]});
		ExpQ.push_back(Total[15:0]);
		ExpQ.push_back(16'h45FF);
		while (!AllDone) @(negedge Clk);
		if (ExpQ.size() != 0)
			reportError($sformatf("%0d stream words missing at AllDone", ExpQ.size()));
		repeat (5) begin
			@(negedge Clk);
			checkLevel("AllDone", AllDone, 1'b1);
		end
		TransmitDone = 1'b1;
		@(negedge Clk);
		TransmitDone = 1'b0;
		checkLevel("AllDone", AllDone, 1'b0);
		checkLevel("DataLost", DataLost, 1'b0);

		$display("Words checked: %0d, errors: %0d", WordCount, ErrorCount);
		if (ErrorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin : watchdog
		repeat (WatchdogCycles) @(posedge Clk);
		$display("Timeout, the run did not finish within %0d clock cycles", WatchdogCycles);
		$display("Words checked: %0d, errors: %0d", WordCount, ErrorCount);
		$display("Errors found");
		$finish;
	end

endmodule

//--- SlaveDaq_assertions.sv
module SlaveDaqAssertions #(
	parameter int CreditDepth = 8
) (
	input logic Clk,
	input logic reset_n,
	input logic DaqDataValid,
	input logic CreditReturn,
	input logic StartAcq,
	input logic TrigEdge,
	input logic ChipFull,
	input logic AllDone
);
	timeunit 1ns;
	timeprecision 1ps;

	int Credits; // Free slots in the sink buffer

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n)
			Credits <= CreditDepth;
		else
			Credits <= Credits - int'(DaqDataValid) + int'(CreditReturn);
	end

	NoValidWithoutCredit: assert property (@(posedge Clk) disable iff (!reset_n)
		DaqDataValid |-> Credits > 0) else $error("DaqDataValid high with no credit left");

	// Window opens on a trigger and stays open only until the chip is full
	AcqOnlyInRun: assert property (@(posedge Clk) disable iff (!reset_n)
		StartAcq |-> ($past(TrigEdge) || ($past(StartAcq) && !$past(ChipFull))))
		else $error("StartAcq high outside an acquisition");

	AllDoneLowAfterReset: assert property (@(posedge Clk) $rose(reset_n) |-> !AllDone)
		else $error("AllDone high right after reset");

endmodule

bind SlaveDaq SlaveDaqAssertions #(.CreditDepth(CreditDepth)) uAssert (
	.Clk(Clk), .reset_n(reset_n), .DaqDataValid(DaqDataValid), .CreditReturn(CreditReturn),
	.StartAcq(StartAcq), .TrigEdge(TrigEdge), .ChipFull(ChipFull), .AllDone(AllDone)
);

//--- run.sh
#!/bin/bash
# Build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module SlaveDaqTb -f src.f -o SlaveDaqSim \
	&& ./obj_dir/SlaveDaqSim 2>&1 | tee sim.log \
	|| echo "Build or simulation run failed"
grep -qx "No errors" sim.log && exit 0 || exit 1

//--- src.f
DaqPkg.sv
InputSync.sv
AcqSequencer.sv
EventFramer.sv
SlaveDaq.sv
SlaveDaq_assertions.sv
SlaveDaqTb.sv
